// ==== verilog/spi_cmd_cfg.svh ====
`ifndef SPI_CMD_CFG_SVH
`define SPI_CMD_CFG_SVH

//////////////////////////////
// Frame widths on the SPI link.
//////////////////////////////

// Command frame: opcode, address, data.
`define SPI_CMD_BITS 56

// Reply frame: status, address low byte, data.
`define SPI_REPLY_BITS 48

//////////////////////////////
// Peripheral sizing.
//////////////////////////////

// Number of 32-bit control registers.
`define REG_COUNT 8

// PWM pins, fed from the low byte of registers 0 and up.
`define PWM_CHANNELS 4

// Flops in each pin synchronizer.
`define SYNC_STAGES 2

`endif

// ==== verilog/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

    //////////////////////////////
    // Scalar types.
    //////////////////////////////

    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // High cycles out of every 256.
    typedef logic [7:0] duty_t;

    //////////////////////////////
    // Command and reply codes.
    //////////////////////////////

    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_READ  = 8'h01,
        OP_WRITE = 8'h02
    } opcode_t;

    typedef enum logic [7:0] {
        ST_OK       = 8'h00,
        ST_BAD_OP   = 8'h01,
        ST_BAD_ADDR = 8'h02
    } status_t;

    //////////////////////////////
    // Frames, MSB first on the wire.
    //////////////////////////////

    typedef struct packed {
        opcode_t   op;
        reg_addr_t addr;
        reg_data_t data;
    } spi_cmd_t;

    typedef struct packed {
        status_t   status;
        logic [7:0] addr_lo;
        reg_data_t data;
    } spi_reply_t;

endpackage

// ==== verilog/sync_sig.sv ====
`include "spi_cmd_cfg.svh"

module sync_sig #(
    parameter bit rst_val = 1'b0
) (
    input  logic clk,
    input  logic nrst,
    input  logic in_sig,
    output logic out_sig
);

    logic [`SYNC_STAGES-1:0] chain;

    // Pin enters at bit 0 and leaves from the top.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            chain <= {`SYNC_STAGES{rst_val}};
        end else begin
            chain <= {chain[`SYNC_STAGES-2:0], in_sig};
        end
    end

    assign out_sig = chain[`SYNC_STAGES-1];

endmodule

// ==== verilog/spi_iff.sv ====
`include "spi_cmd_cfg.svh"

module spi_iff import spi_cmd_pkg::*; (
    input  logic       clk,
    input  logic       nrst,

    input  logic       spi_clk,
    input  logic       spi_ss,
    input  logic       spi_mosi,
    output logic       spi_miso,

    input  spi_reply_t reply,
    output spi_cmd_t   cmd,
    output logic       cmd_valid
);

    logic [`SPI_CMD_BITS-1:0]   in_reg;
    logic [`SPI_REPLY_BITS-1:0] out_reg;

    logic sync_mosi;
    logic sync_sck;
    logic sync_ss;
    logic last_sck;
    logic last_ss;

    logic posedge_sck;
    logic negedge_sck;
    logic posedge_ss;
    logic negedge_ss;

    //////////////////////////////
    // Pin synchronizers.
    //////////////////////////////

    sync_sig #(.rst_val(1'b0)) u_sync_mosi (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_mosi),
        .out_sig (sync_mosi)
    );

    sync_sig #(.rst_val(1'b0)) u_sync_sck (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_clk),
        .out_sig (sync_sck)
    );

    // Select idles high, so it must come out of reset high.
    sync_sig #(.rst_val(1'b1)) u_sync_ss (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_ss),
        .out_sig (sync_ss)
    );

    //////////////////////////////
    // Edge detection.
    //////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            last_sck <= 1'b0;
            last_ss  <= 1'b1;
        end else begin
            last_sck <= sync_sck;
            last_ss  <= sync_ss;
        end
    end

    assign posedge_sck = ~last_sck & sync_sck;
    assign negedge_sck = last_sck & ~sync_sck;
    assign posedge_ss  = ~last_ss & sync_ss;
    assign negedge_ss  = last_ss & ~sync_ss;

    //////////////////////////////
    // Shift registers.
    //////////////////////////////

    // MOSI in on rising sck. A short frame ends up right-aligned.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            in_reg <= '0;
        end else if (negedge_ss) begin
            in_reg <= '0;
        end else if (!sync_ss && posedge_sck) begin
            in_reg <= {in_reg[`SPI_CMD_BITS-2:0], sync_mosi};
        end
    end

    // Reply goes in as select falls, so the MSB is on MISO before the first rising sck.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            out_reg <= '1;
        end else if (negedge_ss) begin
            out_reg <= reply;
        end else if (!sync_ss && negedge_sck) begin
            out_reg <= {out_reg[`SPI_REPLY_BITS-2:0], 1'b1};
        end
    end

    assign spi_miso = out_reg[`SPI_REPLY_BITS-1];

    //////////////////////////////
    // Frame hand-off.
    //////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd       <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (posedge_ss) begin
                cmd       <= spi_cmd_t'(in_reg);
                cmd_valid <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/cmd_exec.sv ====
`include "spi_cmd_cfg.svh"

module cmd_exec import spi_cmd_pkg::*; (
    input  logic                          clk,
    input  logic                          nrst,

    input  spi_cmd_t                      cmd,
    input  logic                          cmd_valid,
    output spi_reply_t                    reply,

    output duty_t [`PWM_CHANNELS-1:0]     duty
);

    localparam int IDX_W = $clog2(`REG_COUNT);

    reg_data_t regs [`REG_COUNT];

    logic             addr_ok;
    logic [IDX_W-1:0] idx;
    logic             wr_en;
    spi_reply_t       reply_next;

    assign addr_ok = (cmd.addr < reg_addr_t'(`REG_COUNT));
    assign idx     = cmd.addr[IDX_W-1:0];

    //////////////////////////////
    // Command decode.
    //////////////////////////////

    always_comb begin
        reply_next.status  = ST_OK;
        reply_next.addr_lo = cmd.addr[7:0];
        reply_next.data    = '0;
        wr_en              = 1'b0;

        case (cmd.op)
            OP_NOP: begin
                reply_next.data = '0;
            end
            OP_READ: begin
                if (addr_ok) begin
                    reply_next.data = regs[idx];
                end else begin
                    reply_next.status = ST_BAD_ADDR;
                end
            end
            OP_WRITE: begin
                if (addr_ok) begin
                    wr_en           = 1'b1;
                    reply_next.data = cmd.data;
                end else begin
                    reply_next.status = ST_BAD_ADDR;
                end
            end
            default: begin
                reply_next.status = ST_BAD_OP;
            end
        endcase
    end

    //////////////////////////////
    // Register bank and reply.
    //////////////////////////////

    // Every strobed command refreshes the reply, NOPs and errors too.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            reply <= '0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (cmd_valid) begin
            reply <= reply_next;
            if (wr_en) begin
                regs[idx] <= cmd.data;
            end
        end
    end

    // Channel i takes the low byte of register i.
    for (genvar i = 0; i < `PWM_CHANNELS; i++) begin : g_duty
        assign duty[i] = regs[i][7:0];
    end

endmodule

// ==== verilog/pwm_out.sv ====
`include "spi_cmd_cfg.svh"

module pwm_out import spi_cmd_pkg::*; (
    input  logic                      clk,
    input  logic                      nrst,

    input  duty_t [`PWM_CHANNELS-1:0] duty,
    output logic  [`PWM_CHANNELS-1:0] pwm
);

    duty_t cnt;

    //////////////////////////////
    // Period counter.
    //////////////////////////////

    // Wraps every 256 cycles.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Compare stage.
    //////////////////////////////

    // Registered outputs keep the pins free of compare glitches.
    // A duty of 0 never fires, 255 leaves one low cycle per period.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pwm <= '0;
        end else begin
            for (int i = 0; i < `PWM_CHANNELS; i++) begin
                pwm[i] <= (cnt < duty[i]);
            end
        end
    end

endmodule

// ==== verilog/spi_cmd_top.sv ====
`include "spi_cmd_cfg.svh"

module spi_cmd_top import spi_cmd_pkg::*; (
    input  logic                      clk,
    input  logic                      nrst,

    input  logic                      spi_clk,
    input  logic                      spi_ss,
    input  logic                      spi_mosi,
    output logic                      spi_miso,

    output logic [`PWM_CHANNELS-1:0]  pwm
);

    spi_cmd_t                   cmd;
    logic                       cmd_valid;
    spi_reply_t                 reply;
    duty_t [`PWM_CHANNELS-1:0]  duty;

    // SPI front end.
    spi_iff u_spi_iff (
        .clk       (clk),
        .nrst      (nrst),
        .spi_clk   (spi_clk),
        .spi_ss    (spi_ss),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .reply     (reply),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    // Decoder and register bank.
    cmd_exec u_cmd_exec (
        .clk       (clk),
        .nrst      (nrst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .reply     (reply),
        .duty      (duty)
    );

    // PWM pins.
    pwm_out u_pwm_out (
        .clk       (clk),
        .nrst      (nrst),
        .duty      (duty),
        .pwm       (pwm)
    );

endmodule

// ==== tests/tb_spi_cmd.sv ====
`include "spi_cmd_cfg.svh"

module tb_spi_cmd import spi_cmd_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic                     clk = 1'b0;
    logic                     nrst;
    logic                     spi_clk;
    logic                     spi_ss;
    logic                     spi_mosi;
    logic                     spi_miso;
    logic [`PWM_CHANNELS-1:0] pwm;

    reg_data_t  model [`REG_COUNT];
    spi_reply_t pending;
    string      pending_name;
    int         pass_cnt;
    int         fail_cnt;
    int         test_fails;

    always #2 clk = ~clk;

    spi_cmd_top u_spi_cmd_top (
        .clk      (clk),
        .nrst     (nrst),
        .spi_clk  (spi_clk),
        .spi_ss   (spi_ss),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .pwm      (pwm)
    );

    //////////////////////////////
    // Helpers.
    //////////////////////////////

    // Lands 0.5 ns after the n-th rising clk edge.
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #0.5;
    endtask

    task automatic check_val(input string name, input logic [47:0] exp,
                             input logic [47:0] act);
        assert (act === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic wait_miso_high(input string where);
        int n;
        n = 0;
        while (spi_miso !== 1'b1 && n < 64) begin
            step(1);
            n++;
        end
        if (spi_miso !== 1'b1) begin
            $display("Timeout: MISO did not return high %s.", where);
            $display(">>> FAIL");
            $finish;
        end
    endtask

    // One SPI transaction with a half-period of 8 clk cycles.
    task automatic spi_xfer(input spi_cmd_t frame, output spi_reply_t rx);
        logic [`SPI_CMD_BITS-1:0]   tx_bits;
        logic [`SPI_REPLY_BITS-1:0] rx_bits;
        tx_bits = frame;
        rx_bits = '0;
        spi_ss  = 1'b0;
        step(8);
        for (int i = `SPI_CMD_BITS - 1; i >= 0; i--) begin
            spi_mosi = tx_bits[i];
            step(8);
            spi_clk = 1'b1;
            // The reply fills the first 48 clocks.
            if (i >= `SPI_CMD_BITS - `SPI_REPLY_BITS) begin
                rx_bits[i - (`SPI_CMD_BITS - `SPI_REPLY_BITS)] = spi_miso;
            end
            step(8);
            spi_clk = 1'b0;
        end
        step(8);
        spi_ss = 1'b1;
        step(12);
        rx = rx_bits;
        wait_miso_high("after a transaction");
    endtask

    // Reference model built from the command rules.
    task automatic model_cmd(input spi_cmd_t c, output spi_reply_t r);
        logic in_range;
        in_range  = (c.addr < `REG_COUNT);
        r.status  = ST_OK;
        r.addr_lo = c.addr[7:0];
        r.data    = '0;
        if ((c.op == OP_READ || c.op == OP_WRITE) && !in_range) begin
            r.status = ST_BAD_ADDR;
        end else if (c.op == OP_WRITE) begin
            model[c.addr] = c.data;
            r.data        = c.data;
        end else if (c.op == OP_READ) begin
            r.data = model[c.addr];
        end else if (c.op != OP_NOP) begin
            r.status = ST_BAD_OP;
        end
    endtask

    // The reply seen now belongs to the previous command.
    task automatic run_cmd(input string name, input logic [7:0] op,
                           input reg_addr_t addr, input reg_data_t data);
        spi_cmd_t   c;
        spi_reply_t rx;
        spi_reply_t exp;
        c.op   = opcode_t'(op);
        c.addr = addr;
        c.data = data;
        spi_xfer(c, rx);
        check_val(pending_name, pending, rx);
        model_cmd(c, exp);
        pending      = exp;
        pending_name = name;
    endtask

    task automatic end_test(input string name);
        run_cmd("flush_nop", OP_NOP, '0, '0);
        $display("test %s done, %0d failures", name, fail_cnt - test_fails);
        test_fails = fail_cnt;
    endtask

    task automatic check_pwm(input int ch, input duty_t d);
        int high;
        high = 0;
        run_cmd("pwm_write", OP_WRITE, reg_addr_t'(ch), {24'($urandom()), d});
        for (int k = 0; k < 256; k++) begin
            step(1);
            high += pwm[ch];
        end
        check_val($sformatf("pwm_ch%0d_duty%0d", ch, d), 48'(d), 48'(high));
    endtask

    //////////////////////////////
    // Test sequence.
    //////////////////////////////

    initial begin
        int         sel;
        logic [7:0] op;
        void'($urandom(32'h1cea));
        nrst         = 1'b0;
        spi_clk      = 1'b0;
        spi_ss       = 1'b1;
        spi_mosi     = 1'b0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        test_fails   = 0;
        pending      = '0;
        pending_name = "reset_reply";
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        step(8);
        nrst = 1'b1;

        check_val("reset_miso", 48'd1, 48'(spi_miso));
        check_val("reset_pwm", 48'd0, 48'(pwm));
        run_cmd("reset_nop", OP_NOP, '0, '0);
        end_test("reset_state");

        for (int r = 0; r < `REG_COUNT; r++) begin
            run_cmd("write_reg", OP_WRITE, reg_addr_t'(r), $urandom());
            run_cmd("read_back", OP_READ, reg_addr_t'(r), '0);
        end
        end_test("write_read");

        run_cmd("bad_op_setup", OP_WRITE, 16'd3, 32'ha5a5_0033);
        run_cmd("bad_op", 8'h7f, 16'd3, 32'hffff_ffff);
        run_cmd("bad_op_read", OP_READ, 16'd3, '0);
        end_test("bad_opcode");

        run_cmd("bad_addr_read", OP_READ, reg_addr_t'(`REG_COUNT), '0);
        run_cmd("bad_addr_write", OP_WRITE, 16'h8001, 32'hdead_beef);
        for (int r = 0; r < `REG_COUNT; r++) begin
            run_cmd("bad_addr_scan", OP_READ, reg_addr_t'(r), '0);
        end
        end_test("bad_address");

        check_pwm(0, 8'd0);
        check_pwm(1, 8'd1);
        check_pwm(2, 8'd128);
        check_pwm(3, 8'd255);
        end_test("pwm_duty");

        // Mix of valid, unknown opcodes and addresses past the bank.
        for (int n = 0; n < 50; n++) begin
            sel = $urandom_range(0, 4);
            case (sel)
                0:       op = OP_NOP;
                1:       op = OP_READ;
                2, 3:    op = OP_WRITE;
                default: op = 8'($urandom());
            endcase
            run_cmd($sformatf("random_%0d", n), op,
                    reg_addr_t'($urandom_range(0, `REG_COUNT + 3)), $urandom());
        end
        end_test("random_sequence");

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/spi_cmd_pkg.sv
verilog/sync_sig.sv
verilog/spi_iff.sv
verilog/cmd_exec.sv
verilog/pwm_out.sv
verilog/spi_cmd_top.sv
tests/tb_spi_cmd.sv

// ==== Bender.yml ====
package:
  name: spi_cmd

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/spi_cmd_pkg.sv
      - verilog/sync_sig.sv
      - verilog/spi_iff.sv
      - verilog/cmd_exec.sv
      - verilog/pwm_out.sv
      - verilog/spi_cmd_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_spi_cmd.sv
